//--- hdl/overlay_params.svh
`ifndef OVERLAY_PARAMS_SVH
`define OVERLAY_PARAMS_SVH

// horizontal raster in pixel clocks, sync first, then back porch, active, front porch
`define H_ACT   64
`define H_FP    4
`define H_SYNC  4
`define H_BP    8
`define H_TOTAL 80

// vertical raster in lines, same order as horizontal
`define V_ACT   48
`define V_FP    2
`define V_SYNC  2
`define V_BP    4
`define V_TOTAL 56

`define N_BOX   4   // boxes drawn by the overlay
`define LINE_W  1   // outline thickness in pixels

`define APB_AW  8

`endif

//--- hdl/overlay_pkg.sv
`default_nettype none
`include "overlay_params.svh"

package overlay_pkg;

    typedef logic [9:0]         coord_t;      // position inside the active area
    typedef logic [7:0]         chan_t;
    typedef logic [15:0]        frame_cnt_t;
    typedef logic [`APB_AW-1:0] apb_addr_t;
    typedef logic [31:0]        apb_data_t;

    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } rgb_t;

    // one pixel slot of the raster, x and y only meaningful while de is high
    typedef struct packed {
        logic   de;
        logic   hsync;
        logic   vsync;
        coord_t x;
        coord_t y;
    } vid_beat_t;

    // corners are inclusive, the outline lies on and inside them
    typedef struct packed {
        logic   en;
        rgb_t   color;
        coord_t x0;
        coord_t x1;
        coord_t y0;
        coord_t y1;
    } box_cfg_t;

    typedef box_cfg_t [`N_BOX-1:0] box_arr_t;

endpackage : overlay_pkg

`default_nettype wire

//--- hdl/video_timing.sv
`timescale 1ns/1ps
`default_nettype none
`include "overlay_params.svh"

module video_timing import overlay_pkg::*; (
    input  wire       pix_clk,
    input  wire       i_arst_n,
    output vid_beat_t o_beat,
    output logic      o_frame_start
);

    localparam int H_ACT_START = `H_SYNC + `H_BP;
    localparam int H_ACT_END   = H_ACT_START + `H_ACT;
    localparam int V_ACT_START = `V_SYNC + `V_BP;
    localparam int V_ACT_END   = V_ACT_START + `V_ACT;

    coord_t    h_cnt;
    coord_t    v_cnt;
    logic      h_act;
    logic      v_act;
    vid_beat_t beat_d;

    // pixel counter wraps every line, line counter steps on each pixel wrap
    always_ff @(posedge pix_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == coord_t'(`H_TOTAL - 1)) begin
            h_cnt <= '0;
            if (v_cnt == coord_t'(`V_TOTAL - 1)) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign h_act = (h_cnt >= coord_t'(H_ACT_START)) && (h_cnt < coord_t'(H_ACT_END));
    assign v_act = (v_cnt >= coord_t'(V_ACT_START)) && (v_cnt < coord_t'(V_ACT_END));

    always_comb begin
        beat_d.de    = h_act && v_act;
        beat_d.hsync = h_cnt < coord_t'(`H_SYNC);   // sync sits at the front of the line
        beat_d.vsync = v_cnt < coord_t'(`V_SYNC);
        // coordinates are rebased so that the first active pixel is (0,0)
        beat_d.x     = h_act ? coord_t'(h_cnt - coord_t'(H_ACT_START)) : '0;
        beat_d.y     = v_act ? coord_t'(v_cnt - coord_t'(V_ACT_START)) : '0;
    end

    always_ff @(posedge pix_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_beat        <= '0;
            o_frame_start <= 1'b0;
        end else begin
            o_beat        <= beat_d;
            o_frame_start <= (h_cnt == '0) && (v_cnt == '0);  // lines up with the beat of (0,0)
        end
    end

endmodule : video_timing

`default_nettype wire

//--- hdl/box_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "overlay_params.svh"

module box_regs import overlay_pkg::*; (
    input  wire            pix_clk,
    input  wire            i_arst_n,
    input  wire            i_psel,
    input  wire            i_penable,
    input  wire            i_pwrite,
    input  wire apb_addr_t i_paddr,
    input  wire apb_data_t i_pwdata,
    output apb_data_t      o_prdata,
    output logic           o_pready,
    output logic           o_pslverr,
    input  wire            i_frame_start,
    output box_arr_t       o_boxes
);

    localparam int        IDX_W     = $clog2(`N_BOX);
    localparam apb_addr_t FCNT_ADDR = apb_addr_t'('h40);

    logic             acc;
    logic             in_box;
    logic             off_ok;
    logic             is_fcnt;
    logic             wr_en;
    logic [IDX_W-1:0] box_idx;
    logic [3:0]       off;
    box_arr_t         shadow_q;
    frame_cnt_t       frame_cnt;

    assign acc     = i_psel && i_penable;
    assign box_idx = i_paddr[4 +: IDX_W];    // each box owns 16 bytes
    assign off     = i_paddr[3:0];
    assign in_box  = i_paddr < apb_addr_t'(`N_BOX * 16);
    assign off_ok  = (off == 4'h0) || (off == 4'h4) || (off == 4'h8);
    assign is_fcnt = i_paddr == FCNT_ADDR;
    assign wr_en   = acc && i_pwrite && in_box && off_ok;

    // zero wait states, so every access phase completes at once
    assign o_pready  = acc;
    assign o_pslverr = acc && !((in_box && off_ok) || (is_fcnt && !i_pwrite));

    always_comb begin
        o_prdata = '0;
        if (acc && in_box) begin
            case (off)
                4'h0: o_prdata = {shadow_q[box_idx].en, 7'b0, shadow_q[box_idx].color};
                4'h4: o_prdata = {6'b0, shadow_q[box_idx].x1, 6'b0, shadow_q[box_idx].x0};
                4'h8: o_prdata = {6'b0, shadow_q[box_idx].y1, 6'b0, shadow_q[box_idx].y0};
                default: o_prdata = '0;
            endcase
        end else if (acc && is_fcnt) begin
            o_prdata = {16'b0, frame_cnt};
        end
    end

    always_ff @(posedge pix_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            shadow_q  <= '0;
            o_boxes   <= '0;
            frame_cnt <= '0;
        end else begin
            if (wr_en) begin
                case (off)
                    4'h0: begin
                        shadow_q[box_idx].en    <= i_pwdata[31];
                        shadow_q[box_idx].color <= rgb_t'(i_pwdata[23:0]);
                    end
                    4'h4: begin
                        shadow_q[box_idx].x0 <= i_pwdata[9:0];
                        shadow_q[box_idx].x1 <= i_pwdata[25:16];
                    end
                    default: begin
                        shadow_q[box_idx].y0 <= i_pwdata[9:0];
                        shadow_q[box_idx].y1 <= i_pwdata[25:16];
                    end
                endcase
            end
            // a write landing on the frame start cycle waits for the next frame
            if (i_frame_start) begin
                o_boxes   <= shadow_q;
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

endmodule : box_regs

`default_nettype wire

//--- hdl/pattern_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_gen import overlay_pkg::*; (
    input  wire            pix_clk,
    input  wire            i_arst_n,
    input  wire vid_beat_t i_beat,
    output vid_beat_t      o_beat,
    output rgb_t           o_rgb
);

    coord_t xy;
    rgb_t   bg;

    assign xy = i_beat.x ^ i_beat.y;

    // ramps in r and g, checker-like texture in b, all wrapping at 8 bits
    always_comb begin
        if (i_beat.de) begin
            bg.r = chan_t'(i_beat.x << 2);
            bg.g = chan_t'(i_beat.y << 2);
            bg.b = chan_t'(xy << 2);
        end else begin
            bg = '0;  // black during blanking
        end
    end

    always_ff @(posedge pix_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_beat <= '0;
            o_rgb  <= '0;
        end else begin
            o_beat <= i_beat;
            o_rgb  <= bg;
        end
    end

endmodule : pattern_gen

`default_nettype wire

//--- hdl/box_overlay.sv
`timescale 1ns/1ps
`default_nettype none
`include "overlay_params.svh"

module box_overlay import overlay_pkg::*; (
    input  wire            pix_clk,
    input  wire            i_arst_n,
    input  wire vid_beat_t i_beat,
    input  wire rgb_t      i_rgb,
    input  wire box_arr_t  i_boxes,
    output vid_beat_t      o_beat,
    output rgb_t           o_rgb
);

    localparam logic [10:0] W = 11'(`LINE_W);

    // one extra bit so that adding the line width never wraps
    logic [10:0]       px;
    logic [10:0]       py;
    logic [`N_BOX-1:0] hit;
    rgb_t              mix;

    assign px = {1'b0, i_beat.x};
    assign py = {1'b0, i_beat.y};

    for (genvar b = 0; b < `N_BOX; b++) begin : g_box
        box_cfg_t    cfg;
        logic [10:0] x0;
        logic [10:0] x1;
        logic [10:0] y0;
        logic [10:0] y1;
        logic        outer;
        logic        inner;

        assign cfg = i_boxes[b];
        assign x0  = {1'b0, cfg.x0};
        assign x1  = {1'b0, cfg.x1};
        assign y0  = {1'b0, cfg.y0};
        assign y1  = {1'b0, cfg.y1};

        assign outer = (px >= x0) && (px <= x1) && (py >= y0) && (py <= y1);
        // inner edges written as px + W <= x1 rather than px <= x1 - W, no underflow on tiny boxes
        assign inner = (px >= x0 + W) && (px + W <= x1)
                    && (py >= y0 + W) && (py + W <= y1);

        assign hit[b] = cfg.en && outer && !inner;
    end

    // later boxes overwrite earlier ones, so the highest index wins
    always_comb begin
        mix = i_rgb;
        for (int b = 0; b < `N_BOX; b++) begin
            if (hit[b]) begin
                mix = i_boxes[b].color;
            end
        end
    end

    always_ff @(posedge pix_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_beat <= '0;
            o_rgb  <= '0;
        end else begin
            o_beat <= i_beat;
            if (i_beat.de) begin
                o_rgb <= mix;  // holds the last active pixel through blanking
            end
        end
    end

endmodule : box_overlay

`default_nettype wire

//--- hdl/video_overlay_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_overlay_top import overlay_pkg::*; (
    input  wire            pix_clk,
    input  wire            i_arst_n,
    input  wire            i_psel,
    input  wire            i_penable,
    input  wire            i_pwrite,
    input  wire apb_addr_t i_paddr,
    input  wire apb_data_t i_pwdata,
    output wire apb_data_t o_prdata,
    output wire            o_pready,
    output wire            o_pslverr,
    output wire rgb_t      o_rgb,
    output wire            o_hsync,
    output wire            o_vsync,
    output wire            o_de
);

    wire vid_beat_t tim_beat;
    wire vid_beat_t pat_beat;
    wire vid_beat_t ovl_beat;
    wire rgb_t      pat_rgb;
    wire box_arr_t  live_boxes;
    wire            frame_start;

    video_timing u_timing (
        .pix_clk       (pix_clk),
        .i_arst_n      (i_arst_n),
        .o_beat        (tim_beat),
        .o_frame_start (frame_start)
    );

    pattern_gen u_pattern (
        .pix_clk  (pix_clk),
        .i_arst_n (i_arst_n),
        .i_beat   (tim_beat),
        .o_beat   (pat_beat),
        .o_rgb    (pat_rgb)
    );

    // live boxes switch one cycle after frame start, in step with the pattern stage
    box_regs u_regs (
        .pix_clk       (pix_clk),
        .i_arst_n      (i_arst_n),
        .i_psel        (i_psel),
        .i_penable     (i_penable),
        .i_pwrite      (i_pwrite),
        .i_paddr       (i_paddr),
        .i_pwdata      (i_pwdata),
        .o_prdata      (o_prdata),
        .o_pready      (o_pready),
        .o_pslverr     (o_pslverr),
        .i_frame_start (frame_start),
        .o_boxes       (live_boxes)
    );

    box_overlay u_overlay (
        .pix_clk  (pix_clk),
        .i_arst_n (i_arst_n),
        .i_beat   (pat_beat),
        .i_rgb    (pat_rgb),
        .i_boxes  (live_boxes),
        .o_beat   (ovl_beat),
        .o_rgb    (o_rgb)
    );

    assign o_hsync = ovl_beat.hsync;
    assign o_vsync = ovl_beat.vsync;
    assign o_de    = ovl_beat.de;

endmodule : video_overlay_top

`default_nettype wire

//--- bench/overlay_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "overlay_params.svh"

module overlay_checker (
    input wire pix_clk,
    input wire i_arst_n,
    input wire i_psel,
    input wire i_penable,
    input wire i_pready,
    input wire i_hsync,
    input wire i_vsync,
    input wire i_de
);

    int         fail_cnt = 0;
    logic       hs_q;
    logic       de_q;
    logic       hs_seen;
    logic [7:0] hs_len;   // cycles of the current hsync pulse so far
    logic [7:0] hs_gap;   // cycles since the last hsync rise
    logic [7:0] de_len;

    always_ff @(posedge pix_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            hs_q    <= 1'b0;
            de_q    <= 1'b0;
            hs_seen <= 1'b0;
            hs_len  <= '0;
            hs_gap  <= '0;
            de_len  <= '0;
        end else begin
            hs_q   <= i_hsync;
            de_q   <= i_de;
            hs_len <= i_hsync ? hs_len + 8'd1 : 8'd0;
            de_len <= i_de ? de_len + 8'd1 : 8'd0;
            if (i_hsync && !hs_q) begin
                hs_seen <= 1'b1;  // the first rise has no period to measure
                hs_gap  <= 8'd1;
            end else begin
                hs_gap <= hs_gap + 8'd1;
            end
        end
    end

    a_hs_width: assert property (@(posedge pix_clk) disable iff (!i_arst_n)
                                 hs_q && !i_hsync |-> hs_len == 8'(`H_SYNC)) else begin
        fail_cnt++;
        $error("hsync pulse lasted %0d cycles", hs_len);
    end

    a_hs_period: assert property (@(posedge pix_clk) disable iff (!i_arst_n)
                                  i_hsync && !hs_q && hs_seen |-> hs_gap == 8'(`H_TOTAL)) else begin
        fail_cnt++;
        $error("hsync period was %0d cycles", hs_gap);
    end

    a_de_count: assert property (@(posedge pix_clk) disable iff (!i_arst_n)
                                 de_q && !i_de |-> de_len == 8'(`H_ACT)) else begin
        fail_cnt++;
        $error("line carried %0d de beats", de_len);
    end

    a_de_blank: assert property (@(posedge pix_clk) disable iff (!i_arst_n)
                                 !(i_de && (i_hsync || i_vsync))) else begin
        fail_cnt++;
        $error("de high during a sync pulse");
    end

    a_pready: assert property (@(posedge pix_clk) disable iff (!i_arst_n)
                               i_psel && i_penable |-> i_pready) else begin
        fail_cnt++;
        $error("pready low in an access phase");
    end

endmodule : overlay_checker

bind video_overlay_top overlay_checker u_checker (
    .pix_clk   (pix_clk),
    .i_arst_n  (i_arst_n),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pready  (o_pready),
    .i_hsync   (o_hsync),
    .i_vsync   (o_vsync),
    .i_de      (o_de)
);

`default_nettype wire

//--- bench/overlay_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "overlay_params.svh"

module overlay_tb import overlay_pkg::*; ();

    localparam int FRAME_CYC = `H_TOTAL * `V_TOTAL;
    localparam int W         = `LINE_W;

    logic        pix_clk = 1'b0;
    logic        i_arst_n;
    logic        i_psel;
    logic        i_penable;
    logic        i_pwrite;
    apb_addr_t   i_paddr;
    apb_data_t   i_pwdata;
    apb_data_t   o_prdata;
    logic        o_pready;
    logic        o_pslverr;
    rgb_t        o_rgb;
    logic        o_hsync;
    logic        o_vsync;
    logic        o_de;
    box_cfg_t    shadow_m [`N_BOX];  // register contents as written over APB
    box_cfg_t    live_m [`N_BOX];    // boxes in force for the frame leaving the DUT
    logic [31:0] lcg_state = 32'd73;
    int          pix_errs = 0;
    int          apb_errs = 0;
    int          box_px = 0;
    int          frames = 0;
    int          px = 0;
    int          py = 0;
    int          hit;
    logic        vs_q = 1'b0;
    logic        de_q = 1'b0;
    rgb_t        want_px;

    always #4 pix_clk = ~pix_clk;

    video_overlay_top i_dut (.*);

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'b0, lcg_state[31:16]};
    endfunction

    function automatic logic on_outline(input box_cfg_t c, input int x, input int y);
        return c.en && x >= c.x0 && x <= c.x1 && y >= c.y0 && y <= c.y1
            && !(x >= c.x0 + W && x <= int'(c.x1) - W && y >= c.y0 + W && y <= int'(c.y1) - W);
    endfunction

    // index of the highest box whose outline covers the pixel, -1 when none does
    function automatic int top_hit(input int x, input int y);
        int idx;
        idx = -1;
        for (int b = 0; b < `N_BOX; b++) begin
            if (on_outline(live_m[b], x, y)) begin
                idx = b;
            end
        end
        return idx;
    endfunction

    function automatic apb_data_t reg_word(input box_cfg_t c, input int off);
        case (off)
            0:       return {c.en, 7'b0, c.color};
            4:       return {6'b0, c.x1, 6'b0, c.x0};
            default: return {6'b0, c.y1, 6'b0, c.y0};
        endcase
    endfunction

    function automatic box_cfg_t rand_box(input rgb_t color);
        box_cfg_t c;
        c.en    = 1'b1;
        c.color = color;
        c.x0    = coord_t'(next_rand() % 48);
        c.x1    = c.x0 + coord_t'(3 + next_rand() % 14);
        c.y0    = coord_t'(next_rand() % 32);
        c.y1    = c.y0 + coord_t'(3 + next_rand() % 14);
        return c;
    endfunction

    task automatic check_word(input string what, input apb_data_t got, input apb_data_t want);
        assert (got == want) else begin
            apb_errs++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, want);
        end
    endtask

    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
        @(posedge pix_clk);
        #1;
        i_psel   = 1'b1;
        i_pwrite = wr;
        i_paddr  = addr;
        i_pwdata = wdata;
        @(posedge pix_clk);
        #1;
        i_penable = 1'b1;
        @(negedge pix_clk);  // middle of the access phase
        check_word("o_pready", 32'(o_pready), 32'd1);
        rdata = o_prdata;
        err   = o_pslverr;
        @(posedge pix_clk);
        #1;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
    endtask

    // writes the three registers of one box, then reads them back
    task automatic write_box(input int b, input box_cfg_t c);
        apb_data_t rd;
        logic      err;
        for (int off = 0; off <= 8; off += 4) begin
            apb_xfer(1'b1, apb_addr_t'(16 * b + off), reg_word(c, off), rd, err);
            check_word("o_pslverr on box write", 32'(err), 32'd0);
        end
        shadow_m[b] = c;
        for (int off = 0; off <= 8; off += 4) begin
            apb_xfer(1'b0, apb_addr_t'(16 * b + off), '0, rd, err);
            check_word("o_prdata on box readback", rd, reg_word(c, off));
        end
    endtask

    task automatic wait_frames(input int n);
        while (frames < n) @(negedge pix_clk);
    endtask

    task automatic wait_line(input int n);
        do @(negedge pix_clk); while (!(o_de && py == n));
    endtask

    // x and y are recovered by counting de beats after each vsync
    always @(negedge pix_clk) begin
        if (o_vsync && !vs_q) begin
            live_m = shadow_m;  // the DUT swaps its live set right at the first beat
            frames++;
            py = 0;
        end
        if (o_de) begin
            hit = top_hit(px, py);
            if (hit >= 0) begin
                want_px = live_m[hit].color;
                box_px++;
            end else begin
                want_px = {chan_t'(4 * px), chan_t'(4 * py), chan_t'(4 * (px ^ py))};
            end
            assert (o_rgb == want_px) else begin
                pix_errs++;
                $display("mismatch at %0t ns: o_rgb at (%0d,%0d) got %h expected %h",
                         $time, px, py, o_rgb, want_px);
            end
            px++;
        end else if (de_q) begin
            px = 0;
            py++;
        end
        vs_q = o_vsync;
        de_q = o_de;
    end

    initial begin
        apb_data_t rd;
        logic      err;
        box_cfg_t  c;
        int        chk_errs;
        i_arst_n  = 1'b0;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = '0;
        i_pwdata  = '0;
        for (int b = 0; b < `N_BOX; b++) begin
            shadow_m[b] = '0;
            live_m[b]   = '0;
        end
        repeat (10) @(posedge pix_clk);
        #1;
        i_arst_n = 1'b1;

        wait_frames(2);  // the whole first frame is plain background

        apb_xfer(1'b0, 8'h0C, '0, rd, err);
        check_word("o_pslverr on unmapped read", 32'(err), 32'd1);
        apb_xfer(1'b0, 8'h40, '0, rd, err);
        check_word("o_pslverr on frame counter read", 32'(err), 32'd0);
        check_word("o_prdata of frame counter", rd, 32'(frames));
        apb_xfer(1'b1, 8'h40, 32'hFFFF, rd, err);
        check_word("o_pslverr on frame counter write", 32'(err), 32'd1);
        apb_xfer(1'b0, 8'h40, '0, rd, err);
        check_word("o_prdata of frame counter after write", rd, 32'(frames));
        apb_xfer(1'b1, 8'h1C, 32'h0123_4567, rd, err);
        check_word("o_pslverr on unmapped write", 32'(err), 32'd1);
        apb_xfer(1'b0, 8'h18, '0, rd, err);
        check_word("o_prdata of box 1 y after bad write", rd, 32'd0);
        apb_xfer(1'b1, 8'h54, 32'h0123_4567, rd, err);
        check_word("o_pslverr on write above the map", 32'(err), 32'd1);
        apb_xfer(1'b0, 8'h14, '0, rd, err);
        check_word("o_prdata of box 1 x after bad write", rd, 32'd0);

        // boxes land mid frame, the output switches only with the next frame
        wait_line(20);
        write_box(0, rand_box(24'hFF0000));
        write_box(1, rand_box(24'h00FF00));
        write_box(2, box_cfg_t'{1'b1, 24'h0000FF, 10'd8, 10'd30, 10'd6, 10'd24});
        write_box(3, box_cfg_t'{1'b1, 24'hFFFF00, 10'd20, 10'd44, 10'd16, 10'd40});
        wait_frames(4);

        wait_line(10);
        apb_xfer(1'b0, 8'h40, '0, rd, err);
        check_word("o_prdata of frame counter", rd, 32'(frames));
        c    = shadow_m[3];
        c.en = 1'b0;
        write_box(3, c);
        wait_frames(5);
        wait_line(10);
        apb_xfer(1'b0, 8'h40, '0, rd, err);
        check_word("o_prdata of frame counter one frame on", rd, 32'(frames));
        wait_frames(6);

        assert (box_px > 0) else begin
            pix_errs++;
            $display("no pixel of a box outline reached the output");
        end
        chk_errs = i_dut.u_checker.fail_cnt;
        $display("errors: pixel %0d, apb %0d, checker %0d", pix_errs, apb_errs, chk_errs);
        if (pix_errs == 0 && apb_errs == 0 && chk_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // the scenarios need a little over five frames
    initial begin
        #(8 * (6 * FRAME_CYC + 2000));
        $display("timeout: the run did not reach its end in time");
        $display("TEST FAIL");
        $finish;
    end

endmodule : overlay_tb

`default_nettype wire

//--- build.f
+incdir+hdl
hdl/overlay_pkg.sv
hdl/video_timing.sv
hdl/box_regs.sv
hdl/pattern_gen.sv
hdl/box_overlay.sv
hdl/video_overlay_top.sv
bench/overlay_checker.sv
bench/overlay_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module overlay_tb -o overlay_sim
	./obj_dir/overlay_sim +verilator+error+limit+100 | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
